/* common/sprite_fetch_if.sv */
`timescale 1ns/1ps

// four-phase attribute fetch, drawer side requests by sprite index
interface sprite_fetch_if import sprite_pkg::*; ();

    logic         req;
    sprite_idx_t  index;
    sprite_attr_t attr;
    logic         ack;

    modport requester (
        output req,
        output index,
        input  attr,
        input  ack
    );

    modport responder (
        input  req,
        input  index,
        output attr,
        output ack
    );

endinterface

/* common/sprite_pkg.sv */
package sprite_pkg;

    // ============================================================
    // load port memory map
    // ============================================================

    typedef logic [16:0] load_addr_t;

    // shared sprite list, 64 records of 4 bytes
    localparam load_addr_t LIST_BASE    = 17'h00000;
    // palette bank per tile pair, 4 bits per entry
    localparam load_addr_t BANK_BASE    = 17'h00100;
    // colour lookup for readout, 4 bits per entry
    localparam load_addr_t COLOUR_BASE  = 17'h00200;
    // sprite pattern bytes, two pens per byte
    localparam load_addr_t PATTERN_BASE = 17'h10000;

    // ============================================================
    // sprite geometry
    // ============================================================

    localparam int NUM_SPRITES = 64;
    localparam int SPRITE_SIZE = 16;
    localparam int LINE_WIDTH  = 256;

    // first list byte counts up from the bottom of the screen
    localparam logic [7:0] Y_ORIGIN = 8'd240;
    localparam logic [8:0] X_BIAS   = 9'h080;

    typedef logic [5:0] sprite_idx_t;
    typedef logic [7:0] line_t;
    typedef logic [7:0] pal_index_t;

    // bank 11:8, colour 7:4, pen 3:0
    typedef logic [11:0] pixel_entry_t;

    // decoded attribute record as held in the buffer
    typedef struct packed {
        logic [9:0] tile;
        logic [8:0] x_pos;
        logic [7:0] y_pos;
        logic [3:0] colour;
        logic       flip_x;
    } sprite_attr_t;

endpackage

/* compile.f */
+incdir+tests
common/sprite_pkg.sv
common/sprite_fetch_if.sv
sprite/sprite_list_copy.sv
sprite/sprite_line_draw.sv
sprite/sprite_pixel_out.sv
logic/sprite_engine_top.sv
tests/tb_sprite_engine.sv

/* logic/sprite_engine_top.sv */
`timescale 1ns/1ps

module sprite_engine_top import sprite_pkg::*; (
    input  logic        clk_sys,
    input  logic        reset,
    input  logic        load_we,
    input  load_addr_t  load_addr,
    input  logic [7:0]  load_data,
    input  logic        vblank,
    input  logic        line_start,
    input  line_t       line,
    input  line_t       pix_x,
    output logic        copy_busy,
    output logic        line_done,
    output pal_index_t  pix_index,
    output logic        pix_opaque
);

    // line buffer write path
    logic         buf_we;
    line_t        buf_addr;
    pixel_entry_t buf_data;

    sprite_fetch_if fetch_if_inst ();

    sprite_list_copy list_copy_inst (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .vblank    (vblank),
        .copy_busy (copy_busy),
        .fetch     (fetch_if_inst.responder)
    );

    sprite_line_draw line_draw_inst (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .line_start (line_start),
        .line       (line),
        .copy_busy  (copy_busy),
        .line_done  (line_done),
        .buf_we     (buf_we),
        .buf_addr   (buf_addr),
        .buf_data   (buf_data),
        .fetch      (fetch_if_inst.requester)
    );

    sprite_pixel_out pixel_out_inst (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .buf_we     (buf_we),
        .buf_addr   (buf_addr),
        .buf_data   (buf_data),
        .pix_x      (pix_x),
        .pix_index  (pix_index),
        .pix_opaque (pix_opaque)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the sprite engine testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f compile.f --top-module tb_sprite_engine \
    -o tb_sprite_engine
sim_out=$(./obj_dir/tb_sprite_engine 2>&1) || true
printf '%s\n' "$sim_out"
if printf '%s\n' "$sim_out" | grep -q "All checks passed"; then
    exit 0
fi
echo "sprite engine simulation did not pass"
exit 1

/* sprite/sprite_line_draw.sv */
`timescale 1ns/1ps

module sprite_line_draw import sprite_pkg::*; (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  logic                     load_we,
    input  load_addr_t               load_addr,
    input  logic [7:0]               load_data,
    input  logic                     line_start,
    input  line_t                    line,
    input  logic                     copy_busy,
    output logic                     line_done,
    output logic                     buf_we,
    output line_t                    buf_addr,
    output pixel_entry_t             buf_data,
    sprite_fetch_if.requester        fetch
);

    typedef enum logic [2:0] {
        DRAW_IDLE,
        DRAW_CLEAR,
        DRAW_FETCH,
        DRAW_TEST,
        DRAW_READ,
        DRAW_WRITE,
        DRAW_NEXT
    } draw_state_t;

    logic [7:0]   pattern_mem [0:65535];
    logic [3:0]   bank_tab [0:255];

    draw_state_t  draw_state;
    line_t        line_q;
    line_t        clr_cnt;
    sprite_idx_t  sprite_cnt;
    sprite_attr_t attr_q;
    logic [3:0]   bank_q;
    logic [3:0]   ofs;
    logic [3:0]   fx;
    logic [3:0]   y_ofs;
    logic [15:0]  pat_addr;
    logic [7:0]   pat_dout;
    logic [3:0]   pen;
    logic [8:0]   px;
    logic [8:0]   y_top;
    logic [8:0]   y_bottom;
    logic         hit;

    // ============================================================
    // pattern memory and bank table
    // ============================================================

    always_ff @(posedge clk_sys) begin
        if (load_we && load_addr[16] == PATTERN_BASE[16]) begin
            pattern_mem[load_addr[15:0]] <= load_data;
        end
        if (load_we && load_addr[16:8] == BANK_BASE[16:8]) begin
            bank_tab[load_addr[7:0]] <= load_data[3:0];
        end
        pat_dout <= pattern_mem[pat_addr];
    end

    // ============================================================
    // hit test and pixel addressing
    // ============================================================

    // bottom edge may pass 255, so compare in 9 bits
    assign y_top    = {1'b0, attr_q.y_pos};
    assign y_bottom = y_top + 9'(SPRITE_SIZE);
    assign hit      = !attr_q.x_pos[8] && ({1'b0, line_q} >= y_top) &&
                      ({1'b0, line_q} < y_bottom);

    assign y_ofs    = 4'(line_q - attr_q.y_pos);
    assign fx       = attr_q.flip_x ? 4'd15 - ofs : ofs;
    assign pat_addr = {fx[1], attr_q.tile[8:0], y_ofs, fx[3:2]};

    // two pens per byte
    assign pen = fx[0] ? pat_dout[7:4] : pat_dout[3:0];
    assign px  = {1'b0, attr_q.x_pos[7:0]} + {5'd0, ofs};

    // ============================================================
    // draw FSM
    // ============================================================

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            draw_state <= DRAW_IDLE;
            line_done  <= 1'b0;
            buf_we     <= 1'b0;
            fetch.req  <= 1'b0;
            clr_cnt    <= '0;
            sprite_cnt <= '0;
            ofs        <= '0;
        end else begin
            line_done <= 1'b0;
            buf_we    <= 1'b0;
            case (draw_state)
                DRAW_IDLE: begin
                    clr_cnt    <= '0;
                    sprite_cnt <= '0;
                    if (line_start) begin
                        line_q     <= line;
                        draw_state <= DRAW_CLEAR;
                    end
                end
                DRAW_CLEAR: begin
                    buf_we   <= 1'b1;
                    buf_addr <= clr_cnt;
                    buf_data <= '0;
                    clr_cnt  <= clr_cnt + 8'd1;
                    if (clr_cnt == line_t'(LINE_WIDTH - 1)) begin
                        draw_state <= DRAW_FETCH;
                    end
                end
                DRAW_FETCH: begin
                    // wait for the previous ack to drop before asking again
                    if (!fetch.req && !fetch.ack) begin
                        fetch.req <= 1'b1;
                    end else if (fetch.req && fetch.ack) begin
                        attr_q     <= fetch.attr;
                        fetch.req  <= 1'b0;
                        draw_state <= DRAW_TEST;
                    end
                end
                DRAW_TEST: begin
                    bank_q     <= bank_tab[attr_q.tile[8:1]];
                    ofs        <= '0;
                    draw_state <= hit ? DRAW_READ : DRAW_NEXT;
                end
                DRAW_READ: begin
                    draw_state <= DRAW_WRITE;
                end
                DRAW_WRITE: begin
                    // pen 0 is transparent, columns past 255 are clipped
                    buf_we   <= (pen != 4'd0) && !px[8];
                    buf_addr <= px[7:0];
                    buf_data <= {bank_q, attr_q.colour, pen};
                    ofs      <= ofs + 4'd1;
                    draw_state <= (ofs == 4'(SPRITE_SIZE - 1)) ? DRAW_NEXT : DRAW_READ;
                end
                DRAW_NEXT: begin
                    if (sprite_cnt == sprite_idx_t'(NUM_SPRITES - 1)) begin
                        line_done  <= 1'b1;
                        draw_state <= DRAW_IDLE;
                    end else begin
                        sprite_cnt <= sprite_cnt + 6'd1;
                        draw_state <= DRAW_FETCH;
                    end
                end
                default: begin
                    draw_state <= DRAW_IDLE;
                end
            endcase
        end
    end

    assign fetch.index = sprite_cnt;

    // the list must not change under a line in progress
    start_outside_copy: assert property (
        @(posedge clk_sys) disable iff (reset)
        line_start |-> !copy_busy
    );

    // index held for the whole request phase
    index_stable_in_req: assert property (
        @(posedge clk_sys) disable iff (reset)
        fetch.req && $past(fetch.req) |-> $stable(fetch.index)
    );

endmodule

/* sprite/sprite_list_copy.sv */
`timescale 1ns/1ps

module sprite_list_copy import sprite_pkg::*; (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  logic                     load_we,
    input  load_addr_t               load_addr,
    input  logic [7:0]               load_data,
    input  logic                     vblank,
    output logic                     copy_busy,
    sprite_fetch_if.responder        fetch
);

    typedef enum logic [1:0] {
        COPY_IDLE,
        COPY_READ,
        COPY_DRAIN
    } copy_state_t;

    logic [7:0]   list_ram [0:255];
    sprite_attr_t attr_buf [0:NUM_SPRITES-1];

    copy_state_t  copy_state;
    logic         vblank_q;
    logic         vblank_rise;
    logic [7:0]   rd_addr;
    logic [7:0]   rd_addr_q;
    logic         rd_valid;
    logic [7:0]   list_dout;
    logic [7:0]   byte0_q;
    logic [7:0]   byte1_q;
    logic [7:0]   byte2_q;

    logic         fetch_pend;
    logic         fetch_take;
    logic         ack_q;
    sprite_attr_t attr_q;

    function automatic sprite_attr_t decode_attr(
        input logic [7:0] b0,
        input logic [7:0] b1,
        input logic [7:0] b2,
        input logic [7:0] b3
    );
        sprite_attr_t a;
        a.y_pos  = Y_ORIGIN - b0;
        a.tile   = {1'b0, b2[1], b1};
        a.flip_x = b2[2];
        a.colour = b2[7:4];
        // bit 0 of byte 2 carries x into the ninth bit
        a.x_pos  = {b2[0], b3} - X_BIAS;
        return a;
    endfunction

    // ============================================================
    // shared list RAM
    // ============================================================

    always_ff @(posedge clk_sys) begin
        if (load_we && load_addr[16:8] == LIST_BASE[16:8]) begin
            list_ram[load_addr[7:0]] <= load_data;
        end
        list_dout <= list_ram[rd_addr];
    end

    // ============================================================
    // vblank copy engine
    // ============================================================

    assign vblank_rise = vblank && !vblank_q;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            vblank_q   <= 1'b0;
            copy_state <= COPY_IDLE;
            copy_busy  <= 1'b0;
            rd_addr    <= '0;
            rd_valid   <= 1'b0;
        end else begin
            vblank_q <= vblank;
            rd_valid <= (copy_state == COPY_READ);
            case (copy_state)
                COPY_IDLE: begin
                    rd_addr <= '0;
                    // edges during a copy are not looked at
                    if (vblank_rise) begin
                        copy_state <= COPY_READ;
                        copy_busy  <= 1'b1;
                    end
                end
                COPY_READ: begin
                    rd_addr <= rd_addr + 8'd1;
                    if (&rd_addr) begin
                        copy_state <= COPY_DRAIN;
                    end
                end
                COPY_DRAIN: begin
                    // last byte comes back one cycle after its read
                    if (rd_valid && &rd_addr_q) begin
                        copy_state <= COPY_IDLE;
                        copy_busy  <= 1'b0;
                    end
                end
                default: begin
                    copy_state <= COPY_IDLE;
                end
            endcase
        end
    end

    // stage bytes 0..2, write the record on byte 3
    always_ff @(posedge clk_sys) begin
        rd_addr_q <= rd_addr;
        if (rd_valid) begin
            case (rd_addr_q[1:0])
                2'd0: byte0_q <= list_dout;
                2'd1: byte1_q <= list_dout;
                2'd2: byte2_q <= list_dout;
                2'd3: attr_buf[rd_addr_q[7:2]] <=
                    decode_attr(byte0_q, byte1_q, byte2_q, list_dout);
                default: byte0_q <= list_dout;
            endcase
        end
        if (fetch_take) begin
            attr_q <= attr_buf[fetch.index];
        end
    end

    // ============================================================
    // fetch responder
    // ============================================================

    assign fetch_take = fetch.req && !ack_q && !fetch_pend;

    // buffer read, then ack on the following cycle
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            fetch_pend <= 1'b0;
            ack_q      <= 1'b0;
        end else if (fetch_take) begin
            fetch_pend <= 1'b1;
        end else if (fetch_pend) begin
            fetch_pend <= 1'b0;
            ack_q      <= 1'b1;
        end else if (ack_q && !fetch.req) begin
            ack_q <= 1'b0;
        end
    end

    assign fetch.ack  = ack_q;
    assign fetch.attr = attr_q;

    // ack only ever answers a request that has been held
    ack_needs_req: assert property (
        @(posedge clk_sys) disable iff (reset)
        $rose(fetch.ack) |-> fetch.req && $past(fetch.req)
    );

endmodule

/* sprite/sprite_pixel_out.sv */
`timescale 1ns/1ps

module sprite_pixel_out import sprite_pkg::*; (
    input  logic         clk_sys,
    input  logic         reset,
    input  logic         load_we,
    input  load_addr_t   load_addr,
    input  logic [7:0]   load_data,
    input  logic         buf_we,
    input  line_t        buf_addr,
    input  pixel_entry_t buf_data,
    input  line_t        pix_x,
    output pal_index_t   pix_index,
    output logic         pix_opaque
);

    pixel_entry_t line_buf [0:LINE_WIDTH-1];
    logic [3:0]   colour_tab [0:255];

    pixel_entry_t entry_q;
    logic [1:0]   bank_sel;

    // ============================================================
    // line buffer and colour table
    // ============================================================

    always_ff @(posedge clk_sys) begin
        if (buf_we) begin
            line_buf[buf_addr] <= buf_data;
        end
        if (load_we && load_addr[16:8] == COLOUR_BASE[16:8]) begin
            colour_tab[load_addr[7:0]] <= load_data[3:0];
        end
        // stage 1
        entry_q <= line_buf[pix_x];
    end

    // ============================================================
    // stage 2, palette index
    // ============================================================

    // pen bit 3 picks the upper half of the bank
    assign bank_sel = entry_q[3] ? entry_q[11:10] : entry_q[9:8];

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            pix_index  <= '0;
            pix_opaque <= 1'b0;
        end else if (entry_q == '0) begin
            pix_index  <= '0;
            pix_opaque <= 1'b0;
        end else begin
            pix_index  <= {2'b10, bank_sel, colour_tab[entry_q[7:0]]};
            pix_opaque <= 1'b1;
        end
    end

endmodule

/* tests/sprite_model.svh */
`ifndef SPRITE_MODEL_SVH
`define SPRITE_MODEL_SVH

// mirrors of every byte written through the load port
logic [7:0]   list_m [0:255];
logic [3:0]   bank_m [0:255];
logic [3:0]   colour_m [0:255];
logic [7:0]   pattern_m [0:65535];
// list contents at the last vblank copy
logic [7:0]   snap_m [0:255];
// expected line buffer after a draw
pixel_entry_t line_m [0:LINE_WIDTH-1];

function automatic void mirror_byte(input load_addr_t addr, input logic [7:0] data);
    if (addr >= PATTERN_BASE) begin
        pattern_m[addr[15:0]] = data;
    end else if (addr >= COLOUR_BASE && addr < COLOUR_BASE + 17'd256) begin
        colour_m[8'(addr - COLOUR_BASE)] = data[3:0];
    end else if (addr >= BANK_BASE && addr < BANK_BASE + 17'd256) begin
        bank_m[8'(addr - BANK_BASE)] = data[3:0];
    end else if (addr < LIST_BASE + 17'd256) begin
        list_m[8'(addr - LIST_BASE)] = data;
    end
endfunction

function automatic void take_snapshot();
    for (int i = 0; i < 256; i++) begin
        snap_m[8'(i)] = list_m[8'(i)];
    end
endfunction

// clear, then draw every sprite in index order
function automatic void draw_model(input line_t l);
    logic [7:0] b0;
    logic [7:0] b1;
    logic [7:0] b2;
    logic [7:0] b3;
    logic [7:0] y;
    logic [8:0] x;
    logic [8:0] tile;
    logic [3:0] fx;
    logic [3:0] y_ofs;
    logic [7:0] pat;
    logic [3:0] pen;
    logic [8:0] pos;
    for (int i = 0; i < LINE_WIDTH; i++) begin
        line_m[8'(i)] = '0;
    end
    for (int n = 0; n < NUM_SPRITES; n++) begin
        b0   = snap_m[8'(4 * n)];
        b1   = snap_m[8'(4 * n + 1)];
        b2   = snap_m[8'(4 * n + 2)];
        b3   = snap_m[8'(4 * n + 3)];
        y    = 8'd240 - b0;
        tile = {b2[1], b1};
        x    = {b2[0], b3} - 9'h080;
        if (!x[8] && {1'b0, l} >= {1'b0, y} && {1'b0, l} < {1'b0, y} + 9'd16) begin
            y_ofs = 4'(l - y);
            for (int o = 0; o < SPRITE_SIZE; o++) begin
                fx  = b2[2] ? 4'(15 - o) : 4'(o);
                pat = pattern_m[{fx[1], tile, y_ofs, fx[3:2]}];
                pen = fx[0] ? pat[7:4] : pat[3:0];
                pos = x + 9'(o);
                if (pen != 4'd0 && pos < 9'd256) begin
                    line_m[pos[7:0]] = {bank_m[tile[8:1]], b2[7:4], pen};
                end
            end
        end
    end
endfunction

// palette index for one line buffer entry
function automatic pal_index_t expect_index(input pixel_entry_t e);
    logic [1:0] bank_bits;
    if (e == '0) begin
        return '0;
    end
    bank_bits = e[3] ? e[11:10] : e[9:8];
    return {2'b10, bank_bits, colour_m[e[7:0]]};
endfunction

`endif

/* tests/tb_sprite_engine.sv */
`timescale 1ns/1ps

module tb_sprite_engine import sprite_pkg::*; ();

    // one full copy of 256 bytes plus pipeline slack
    localparam int COPY_LIMIT = 270;
    localparam int DRAW_LIMIT = 6000;
    // cycles into a copy for the second vblank edge
    localparam int MID_COPY   = 128;

    logic       clk_sys;
    logic       reset;
    logic       load_we;
    load_addr_t load_addr;
    logic [7:0] load_data;
    logic       vblank;
    logic       line_start;
    line_t      line;
    line_t      pix_x;
    logic       copy_busy;
    logic       line_done;
    pal_index_t pix_index;
    logic       pix_opaque;

    logic [31:0] lcg_state = 32'h647d;

    `include "sprite_model.svh"

    sprite_engine_top sprite_engine_top_inst (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .vblank     (vblank),
        .line_start (line_start),
        .line       (line),
        .pix_x      (pix_x),
        .copy_busy  (copy_busy),
        .line_done  (line_done),
        .pix_index  (pix_index),
        .pix_opaque (pix_opaque)
    );

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    // ============================================================
    // helpers
    // ============================================================

    function automatic logic [7:0] rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    // inputs change 1 ns after the edge
    task automatic step_cycle();
        @(posedge clk_sys);
        #1;
    endtask

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_pixel(input string name, input pal_index_t exp_index,
                               input logic exp_opaque, input pal_index_t act_index,
                               input logic act_opaque);
        string msg;
        if (act_index !== exp_index || act_opaque !== exp_opaque) begin
            msg = $sformatf("error %s: expected index %02h opaque %0b",
                            name, exp_index, exp_opaque);
            msg = {msg, $sformatf(", actual index %02h opaque %0b", act_index, act_opaque)};
            stop_run(msg);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("error %s: expected %0b, actual %0b", name, exp, act));
        end
    endtask

    task automatic load_byte(input load_addr_t addr, input logic [7:0] data);
        step_cycle();
        load_we   = 1'b1;
        load_addr = addr;
        load_data = data;
        mirror_byte(addr, data);
    endtask

    task automatic finish_load();
        step_cycle();
        load_we = 1'b0;
    endtask

    task automatic write_sprite(input int n, input logic [7:0] b0, input logic [7:0] b1,
                                input logic [7:0] b2, input logic [7:0] b3);
        load_byte(LIST_BASE + load_addr_t'(4 * n), b0);
        load_byte(LIST_BASE + load_addr_t'(4 * n + 1), b1);
        load_byte(LIST_BASE + load_addr_t'(4 * n + 2), b2);
        load_byte(LIST_BASE + load_addr_t'(4 * n + 3), b3);
    endtask

    // same byte for all 16 pixels of one row of a tile
    task automatic load_sprite_row(input logic [8:0] tile, input logic [3:0] y_ofs,
                                   input logic [7:0] data);
        logic [3:0] f;
        for (int i = 0; i < SPRITE_SIZE; i++) begin
            f = 4'(i);
            load_byte(PATTERN_BASE + load_addr_t'({f[1], tile, y_ofs, f[3:2]}), data);
        end
    endtask

    task automatic load_list(input logic fill_random);
        for (int i = 0; i < 256; i++) begin
            load_byte(LIST_BASE + load_addr_t'(i), fill_random ? rand_byte() : 8'h00);
        end
        finish_load();
    endtask

    task automatic wait_copy_busy(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (copy_busy !== level) begin
            if (n == limit) begin
                stop_run($sformatf("copy_busy did not go to %0b in time during %s", level, what));
            end
            step_cycle();
            n++;
        end
    endtask

    task automatic run_copy();
        step_cycle();
        vblank = 1'b1;
        take_snapshot();
        wait_copy_busy(1'b1, 4, "copy start");
        wait_copy_busy(1'b0, COPY_LIMIT, "copy end");
        step_cycle();
        vblank = 1'b0;
    endtask

    task automatic draw_line(input line_t l);
        int n;
        step_cycle();
        line_start = 1'b1;
        line       = l;
        step_cycle();
        line_start = 1'b0;
        n = 0;
        while (line_done !== 1'b1) begin
            if (n == DRAW_LIMIT) begin
                stop_run($sformatf("line_done never pulsed for line %0d", l));
            end
            step_cycle();
            n++;
        end
        draw_model(l);
    endtask

    // pixel x comes out two cycles after it is presented
    task automatic read_line(input string name);
        pixel_entry_t e;
        for (int x = 0; x < LINE_WIDTH + 2; x++) begin
            step_cycle();
            if (x >= 2) begin
                e = line_m[8'(x - 2)];
                check_pixel($sformatf("%s x=%0d", name, x - 2), expect_index(e),
                            e != '0, pix_index, pix_opaque);
            end
            if (x < LINE_WIDTH) begin
                pix_x = line_t'(x);
            end
        end
    endtask

    // ============================================================
    // test sequence
    // ============================================================

    initial begin
        reset      = 1'b1;
        load_we    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        vblank     = 1'b0;
        line_start = 1'b0;
        line       = '0;
        pix_x      = '0;
        repeat (5) step_cycle();
        reset = 1'b0;

        // after reset, empty list
        check_flag("reset_copy_busy", 1'b0, copy_busy);
        check_flag("reset_line_done", 1'b0, line_done);
        load_list(1'b0);
        run_copy();
        draw_line(8'd100);
        read_line("empty_list");

        // random tables and patterns
        for (int i = 0; i < 256; i++) begin
            load_byte(BANK_BASE + load_addr_t'(i), rand_byte());
            load_byte(COLOUR_BASE + load_addr_t'(i), rand_byte());
        end
        for (int i = 0; i < 65536; i++) begin
            load_byte(PATTERN_BASE + load_addr_t'(i), rand_byte());
        end
        load_list(1'b1);

        // second vblank edge in the middle of a copy
        step_cycle();
        vblank = 1'b1;
        take_snapshot();
        wait_copy_busy(1'b1, 4, "first vblank edge");
        step_cycle();
        vblank = 1'b0;
        repeat (MID_COPY - 2) step_cycle();
        check_flag("copy_busy_mid_copy", 1'b1, copy_busy);
        vblank = 1'b1;
        // a restarted copy would run well past one full copy from here
        wait_copy_busy(1'b0, COPY_LIMIT - MID_COPY, "copy with a second vblank edge");
        repeat (4) step_cycle();
        check_flag("copy_no_restart", 1'b0, copy_busy);
        vblank = 1'b0;

        // random lines over two lists, the new one shows only after its copy
        for (int k = 0; k < 20; k++) begin
            if (k == 10) begin
                load_list(1'b1);
            end
            if (k == 15) begin
                run_copy();
            end
            draw_line(rand_byte());
            read_line($sformatf("random_line_%0d", k));
        end

        // later sprite on top, its zero pens show the earlier one
        load_list(1'b0);
        load_sprite_row(9'h010, 4'd3, 8'h33);
        load_sprite_row(9'h020, 4'd3, 8'h50);
        write_sprite(0, 8'd190, 8'h10, 8'h20, 8'hc0);
        write_sprite(1, 8'd190, 8'h20, 8'h50, 8'hc0);
        finish_load();
        run_copy();
        draw_line(8'd53);
        read_line("overlap");

        // mirrored, clipped at 255, and off screen
        load_list(1'b0);
        write_sprite(2, 8'd140, 8'h31, 8'h74, 8'ha0);
        write_sprite(3, 8'd140, 8'h45, 8'h91, 8'h78);
        write_sprite(4, 8'd140, 8'h50, 8'h30, 8'h10);
        finish_load();
        run_copy();
        draw_line(8'd105);
        read_line("flip_clip");

        $display("All checks passed");
        $finish;
    end

endmodule
